/* build.f */
+incdir+hw
+incdir+testbench
hw/dtpu_pkg.sv
hw/dtpu_line_mem.sv
hw/dtpu_loader.sv
hw/dtpu_issue.sv
hw/dtpu_traverse.sv
hw/dtpu_top.sv
testbench/dtpu_tb.sv

/* Makefile */
# Verilator flow for the decision-tree inference unit
VERILATOR ?= verilator
TOP       ?= dtpu_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing --assert
LFLAGS    ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LFLAGS) -f $(FILELIST) --top-module $(TOP)

# The run's own status is ignored, the log decides pass or fail
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* testbench/dtpu_tb_ref.svh */
`ifndef DTPU_TB_REF_SVH
`define DTPU_TB_REF_SVH

////////////////////////////////////////////////////////////////////////////
// Host-side copies of the programmed trees and the stored tuples
////////////////////////////////////////////////////////////////////////////

logic [`DTPU_WORD_W-1:0] wmem [256];                      // Thresholds and leaves by node address
dtpu_pkg::fidx_entry_t    xmem [256];                      // Index entries by node address
logic [`DTPU_WORD_W-1:0] tuple_mem [`DTPU_SLOTS][16];     // Features of each slot
dtpu_pkg::cfg_t          ref_cfg;                         // Configuration last sent
logic [31:0]             lfsr_state = 32'h44734470;

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsr_bit();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	r = '0;
	for (int i = 0; i < n; i++) begin
		r = {r[30:0], lfsr_bit()};
	end
	return r;
endfunction

// Walk one tree for the tuple in a slot and return its leaf word
function automatic logic [`DTPU_WORD_W-1:0] ref_leaf(input int slot, input int tree);
	logic [7:0]              base;
	logic [7:0]              off;
	logic [7:0]              a;
	logic [`DTPU_WORD_W-1:0] f;
	logic                    right;
	base = 8'(tree * ref_cfg.tree_stride);
	off  = '0;                                              // Root
	for (int lvl = 0; lvl <= ref_cfg.last_level; lvl++) begin
		a = base + off;
		f = tuple_mem[slot][xmem[a].feat_idx[3:0]];
		if (f == ref_cfg.missing_value) begin
			right = xmem[a].missing_right;                  // Missing feature takes the flag
		end else begin
			right = $signed(f) >= $signed(wmem[a]);         // Not below threshold goes right
		end
		off = 8'(2 * off + 1 + right);
	end
	return wmem[8'(base + off)];                            // Leaf sits after the last compare
endfunction

`endif

/* testbench/dtpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dtpu_consts.svh"

module dtpu_tb;

	localparam int STRIDE     = 16;                       // Node words per tree
	localparam int MAX_CYCLES = 40 * 4 * 30 + 2000;       // Random run plus the short tests

	logic               clk = 1'b0;
	logic               rst_n;
	logic               in_valid;
	dtpu_pkg::in_line_t in_line;
	logic               ready;
	logic               leaf_valid;
	dtpu_pkg::leaf_t    leaf;

	dtpu_pkg::leaf_t exp_q [$];                          // Leaves still owed, in output order
	dtpu_pkg::leaf_t head_leaf;
	int              errors       = 0;
	int              err_mark     = 0;
	int              leaf_count   = 0;
	int              leaf_mark    = 0;
	int              tuple_count  = 0;                   // Slot is this count mod 16
	int              tests_run    = 0;
	int              tests_failed = 0;
	int              cycles       = 0;

	`include "dtpu_tb_ref.svh"

	dtpu_top u_dtpu_top (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_line    (in_line),
		.ready      (ready),
		.leaf_valid (leaf_valid),
		.leaf       (leaf)
	);

	always #5 clk = ~clk;   // 10 ns period

////////////////////////////////////////////////////////////////////////////
// Stimulus helpers, all entered and left on a falling edge
////////////////////////////////////////////////////////////////////////////

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] expd);
		errors++;
		$display("Error at %0t ns: %s = %h, expected %h", $time, name, got, expd);
	endtask

	task automatic send_line(input dtpu_pkg::line_kind_t kind, input logic last,
		input dtpu_pkg::in_data_u data);
		in_valid     = 1'b1;
		in_line.kind = kind;
		in_line.last = last;
		in_line.data = data;
		@(negedge clk);
		in_valid = 1'b0;                                    // Next call may raise it again
	endtask

	task automatic send_config(input int trees, input int last_lvl, input logic [31:0] missing);
		dtpu_pkg::in_data_u d;
		d                     = '0;
		ref_cfg               = '0;
		ref_cfg.missing_value = missing;
		ref_cfg.num_trees_m1  = 4'(trees - 1);
		ref_cfg.last_level    = 4'(last_lvl);
		ref_cfg.tree_stride   = 8'(STRIDE);
		ref_cfg.tuple_lines   = 3'd4;
		d.cfg_line.cfg        = ref_cfg;
		send_line(dtpu_pkg::KIND_CONFIG, 1'b0, d);
	endtask

	// Four trees of 16 node words, thresholds then leaves
	task automatic program_trees();
		dtpu_pkg::in_data_u d;
		logic [7:0][15:0]   xl;
		for (int a = 0; a < 4 * STRIDE; a++) begin
			wmem[a]               = rand_bits(32);
			xmem[a]               = '0;
			xmem[a].missing_right = rand_bits(1);
			xmem[a].feat_idx      = 12'(rand_bits(4));     // Any of 16 tuple words
		end
		for (int l = 0; l < STRIDE; l++) begin             // 4 words per line
			d = '0;
			for (int i = 0; i < 4; i++) begin
				d.words[i] = wmem[l * 4 + i];
			end
			send_line(dtpu_pkg::KIND_WEIGHTS, 1'b0, d);
		end
		for (int l = 0; l < STRIDE / 2; l++) begin         // 8 entries per line
			for (int j = 0; j < 8; j++) begin
				xl[j] = xmem[l * 8 + j];
			end
			d.words = xl;
			send_line(dtpu_pkg::KIND_FINDEX, 1'b0, d);
		end
	endtask

	// Every miss_step-th feature is the missing value, 0 for none
	task automatic send_tuple(input int miss_step);
		dtpu_pkg::in_data_u d;
		dtpu_pkg::leaf_t    next_leaf;
		int                 slot;
		slot = tuple_count % `DTPU_SLOTS;
		for (int w = 0; w < 16; w++) begin
			if (miss_step != 0 && w % miss_step == 0) begin
				tuple_mem[slot][w] = ref_cfg.missing_value;
			end else begin
				tuple_mem[slot][w] = rand_bits(32);
			end
		end
		for (int l = 0; l < 4; l++) begin
			while (ready !== 1'b1) begin
				@(negedge clk);                             // Tuple lines only while ready
			end
			for (int i = 0; i < 4; i++) begin
				d.words[i] = tuple_mem[slot][l * 4 + i];
			end
			send_line(dtpu_pkg::KIND_TUPLE, l == 3, d);
		end
		for (int t = 0; t <= ref_cfg.num_trees_m1; t++) begin
			next_leaf.value = ref_leaf(slot, t);
			next_leaf.tree  = 4'(t);
			next_leaf.slot  = 4'(slot);
			next_leaf.last  = t == ref_cfg.num_trees_m1;
			exp_q.push_back(next_leaf);
		end
		tuple_count++;
	endtask

	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);                          // Room for a stray extra leaf
	endtask

	task automatic check_leaves(input int n);
		assert (leaf_count - leaf_mark == n)
			else report_value("leaf count", 32'(leaf_count - leaf_mark), 32'(n));
		leaf_mark = leaf_count;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == err_mark) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: failed, %0d errors", tests_run, name, errors - err_mark);
		end
		err_mark = errors;
	endtask

////////////////////////////////////////////////////////////////////////////
// Leaf checker
////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (rst_n && leaf_valid) begin
			leaf_count++;
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("Leaf at %0t ns came out with no tuple waiting for it", $time);
			end
			if (exp_q.size() != 0) begin
				head_leaf = exp_q.pop_front();
				assert (leaf.value == head_leaf.value)
					else report_value("leaf.value", leaf.value, head_leaf.value);
				assert (leaf.tree == head_leaf.tree)
					else report_value("leaf.tree", 32'(leaf.tree), 32'(head_leaf.tree));
				assert (leaf.slot == head_leaf.slot)
					else report_value("leaf.slot", 32'(leaf.slot), 32'(head_leaf.slot));
				assert (leaf.last == head_leaf.last)
					else report_value("leaf.last", 32'(leaf.last), 32'(head_leaf.last));
			end
		end
	end

	// Run limit
	initial begin
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout after %0d cycles with %0d leaves still owed", cycles, exp_q.size());
		$display("FAIL: see errors above");
		$finish;
	end

////////////////////////////////////////////////////////////////////////////
// Test sequence
////////////////////////////////////////////////////////////////////////////

	initial begin
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in_line  = '0;
		@(posedge clk);                                     // First reset edge
		repeat (10) begin
			@(negedge clk);
			assert (ready === 1'b0) else report_value("ready", 32'(ready), 32'd0);
			assert (leaf_valid === 1'b0) else report_value("leaf_valid", 32'(leaf_valid), 32'd0);
		end
		rst_n = 1'b1;
		@(negedge clk);
		assert (leaf_valid === 1'b0) else report_value("leaf_valid", 32'(leaf_valid), 32'd0);
		send_config(4, 2, rand_bits(32));
		program_trees();
		for (int i = 0; i < 20 && ready !== 1'b1; i++) begin
			@(negedge clk);
		end
		assert (ready === 1'b1) else begin
			errors++;
			$display("ready did not rise after configuration and programming");
		end
		finish_test("reset and programming");

		send_tuple(0);
		wait_drain();
		check_leaves(4);
		finish_test("one tuple, four trees");

		send_tuple(1);                                      // All features missing
		send_tuple(3);                                      // Some missing
		wait_drain();
		check_leaves(8);
		finish_test("missing features");

		repeat (40) send_tuple(0);                          // Back to back, paced by ready
		wait_drain();
		check_leaves(160);
		finish_test("40 random tuples");

		send_config(2, 2, ref_cfg.missing_value);           // Two trees from here on
		repeat (4) send_tuple(0);
		wait_drain();
		check_leaves(8);
		finish_test("two-tree configuration");

		$display("Tests run %0d, failed %0d, errors %0d, leaves %0d",
			tests_run, tests_failed, errors, leaf_count);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hw/dtpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dtpu_consts.svh"

module dtpu_top (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       in_valid,
	input  wire dtpu_pkg::in_line_t   in_line,
	output logic                      ready,
	output logic                      leaf_valid,
	output dtpu_pkg::leaf_t           leaf
);

	dtpu_pkg::cfg_t                                   cfg;
	logic                                             w_we;
	logic [`DTPU_NODE_AW-`DTPU_WORD_SEL_W-1:0]        w_addr;
	logic [`DTPU_LINE_W-1:0]                          w_line;
	logic                                             x_we;
	logic [`DTPU_NODE_AW-`DTPU_FIDX_SEL_W-1:0]        x_addr;
	logic [`DTPU_LINE_W-1:0]                          x_line;
	logic                                             f_we;
	logic [`DTPU_SLOT_W+`DTPU_SLOT_LINE_W-1:0]        f_addr;
	logic [`DTPU_LINE_W-1:0]                          f_line;
	logic                                             tuple_done;
	logic                                             slot_free;
	logic                                             issue_valid;
	dtpu_pkg::instr_t                                 issue;
	logic                                             recirc_valid;
	dtpu_pkg::instr_t                                 recirc;
	logic                                             node_rd;
	logic [`DTPU_NODE_AW-1:0]                         node_addr;
	logic                                             node_valid;
	logic [`DTPU_WORD_W-1:0]                          node_data;
	logic                                             idx_rd;
	logic [`DTPU_NODE_AW-1:0]                         idx_addr;
	logic                                             idx_valid;
	dtpu_pkg::fidx_entry_t                            idx_data;
	logic                                             feat_rd;
	logic [`DTPU_FEAT_AW-1:0]                         feat_addr;
	logic                                             feat_valid;
	logic [`DTPU_WORD_W-1:0]                          feat_data;
	logic                                             leaf_rd;
	logic [`DTPU_NODE_AW-1:0]                         leaf_addr;
	logic                                             leaf_data_valid;
	logic [`DTPU_WORD_W-1:0]                          leaf_data;

	dtpu_loader u_loader (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_line    (in_line),
		.ready      (ready),
		.cfg        (cfg),
		.w_we       (w_we),
		.w_addr     (w_addr),
		.w_line     (w_line),
		.x_we       (x_we),
		.x_addr     (x_addr),
		.x_line     (x_line),
		.f_we       (f_we),
		.f_addr     (f_addr),
		.f_line     (f_line),
		.tuple_done (tuple_done),
		.slot_free  (slot_free)
	);

	dtpu_issue u_issue (
		.clk          (clk),
		.rst_n        (rst_n),
		.cfg          (cfg),
		.tuple_done   (tuple_done),
		.recirc_valid (recirc_valid),
		.issue_valid  (issue_valid),
		.issue        (issue)
	);

	dtpu_traverse u_traverse (
		.clk             (clk),
		.rst_n           (rst_n),
		.cfg             (cfg),
		.issue_valid     (issue_valid),
		.issue           (issue),
		.recirc_valid    (recirc_valid),
		.recirc          (recirc),
		.node_rd         (node_rd),
		.node_addr       (node_addr),
		.idx_rd          (idx_rd),
		.idx_addr        (idx_addr),
		.node_valid      (node_valid),
		.node_data       (node_data),
		.idx_valid       (idx_valid),
		.idx_data        (idx_data),
		.feat_rd         (feat_rd),
		.feat_addr       (feat_addr),
		.feat_valid      (feat_valid),
		.feat_data       (feat_data),
		.leaf_rd         (leaf_rd),
		.leaf_addr       (leaf_addr),
		.leaf_data_valid (leaf_data_valid),
		.leaf_data       (leaf_data),
		.leaf_valid      (leaf_valid),
		.leaf            (leaf),
		.slot_free       (slot_free)
	);

////////////////////////////////////////////////////////////////////////////
// Memories
////////////////////////////////////////////////////////////////////////////

	// Thresholds and leaves share one array, port 1 serves leaf reads
	dtpu_line_mem #(
		.WORD_W (`DTPU_WORD_W),
		.AW     (`DTPU_NODE_AW),
		.NUM_RD (2)
	) u_weight_mem (
		.clk        (clk),
		.rst_n      (rst_n),
		.we         (w_we),
		.waddr      (w_addr),
		.din        (w_line),
		.re         ({leaf_rd, node_rd}),
		.raddr      ({leaf_addr, node_addr}),
		.dout       ({leaf_data, node_data}),
		.dout_valid ({leaf_data_valid, node_valid})
	);

	dtpu_line_mem #(
		.WORD_W (`DTPU_FIDX_W),
		.AW     (`DTPU_NODE_AW),
		.NUM_RD (1)
	) u_index_mem (
		.clk        (clk),
		.rst_n      (rst_n),
		.we         (x_we),
		.waddr      (x_addr),
		.din        (x_line),
		.re         (idx_rd),
		.raddr      (idx_addr),
		.dout       (idx_data),
		.dout_valid (idx_valid)
	);

	dtpu_line_mem #(
		.WORD_W (`DTPU_WORD_W),
		.AW     (`DTPU_FEAT_AW),
		.NUM_RD (1)
	) u_feature_mem (
		.clk        (clk),
		.rst_n      (rst_n),
		.we         (f_we),
		.waddr      (f_addr),
		.din        (f_line),
		.re         (feat_rd),
		.raddr      (feat_addr),
		.dout       (feat_data),
		.dout_valid (feat_valid)
	);

	// Host sends tuple lines only while a slot is free
	assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && in_line.kind == dtpu_pkg::KIND_TUPLE |-> ready);

endmodule

`default_nettype wire

/* hw/dtpu_traverse.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dtpu_consts.svh"

module dtpu_traverse (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire dtpu_pkg::cfg_t          cfg,
	input  wire                          issue_valid,
	input  wire dtpu_pkg::instr_t        issue,
	output logic                         recirc_valid,
	output dtpu_pkg::instr_t             recirc,
	output logic                         node_rd,
	output logic [`DTPU_NODE_AW-1:0]     node_addr,
	output logic                         idx_rd,
	output logic [`DTPU_NODE_AW-1:0]     idx_addr,
	input  wire                          node_valid,
	input  wire  [`DTPU_WORD_W-1:0]      node_data,
	input  wire                          idx_valid,
	input  wire dtpu_pkg::fidx_entry_t   idx_data,
	output logic                         feat_rd,
	output logic [`DTPU_FEAT_AW-1:0]     feat_addr,
	input  wire                          feat_valid,
	input  wire  [`DTPU_WORD_W-1:0]      feat_data,
	output logic                         leaf_rd,
	output logic [`DTPU_NODE_AW-1:0]     leaf_addr,
	input  wire                          leaf_data_valid,
	input  wire  [`DTPU_WORD_W-1:0]      leaf_data,
	output logic                         leaf_valid,
	output dtpu_pkg::leaf_t              leaf,
	output logic                         slot_free
);

	localparam int LAT = `DTPU_MEM_PIPE + 1;   // Read latency of every memory
	localparam int W   = `DTPU_WORD_W;

	dtpu_pkg::instr_t         s1_in;
	dtpu_pkg::instr_t         s1_q  [LAT];   // Waits on node and index words
	dtpu_pkg::instr_t         s2_q  [LAT];   // Waits on the feature word
	logic [W-1:0]             thr_q [LAT];   // Threshold rides along
	logic [LAT-1:0]           mr_q;          // Missing-right flag rides along
	dtpu_pkg::instr_t         lf_q  [LAT];   // Leaf tag while the leaf is read
	logic                     feat_lt;
	logic                     feat_miss;
	logic                     go_right;
	logic                     cmp_v;
	logic                     cmp_right;
	logic                     cmp_last;      // Compare was on the last level
	dtpu_pkg::instr_t         cmp_ins;
	logic [`DTPU_NODE_AW-1:0] child;

////////////////////////////////////////////////////////////////////////////
// Read node and index
////////////////////////////////////////////////////////////////////////////

	assign s1_in     = recirc_valid ? recirc : issue;
	assign node_rd   = recirc_valid || issue_valid;
	assign idx_rd    = node_rd;
	assign node_addr = s1_in.node_addr;
	assign idx_addr  = s1_in.node_addr;   // One address serves both memories

////////////////////////////////////////////////////////////////////////////
// Read feature
////////////////////////////////////////////////////////////////////////////

	assign feat_rd   = node_valid && idx_valid;
	assign feat_addr = {s1_q[LAT-1].slot, {(`DTPU_FEAT_AW-`DTPU_SLOT_W){1'b0}}}
		+ idx_data.feat_idx[`DTPU_FEAT_AW-1:0];   // slot * 16 + index

	// Payload delay lines
	always_ff @(posedge clk) begin
		s1_q[0]  <= s1_in;
		s2_q[0]  <= s1_q[LAT-1];
		thr_q[0] <= node_data;
		mr_q[0]  <= idx_data.missing_right;
		lf_q[0]  <= recirc;
		for (int i = 1; i < LAT; i++) begin
			s1_q[i]  <= s1_q[i-1];
			s2_q[i]  <= s2_q[i-1];
			thr_q[i] <= thr_q[i-1];
			mr_q[i]  <= mr_q[i-1];
			lf_q[i]  <= lf_q[i-1];
		end
	end

////////////////////////////////////////////////////////////////////////////
// Compare and route
////////////////////////////////////////////////////////////////////////////

	// Flipping the sign bit orders signed words as unsigned ones
	assign feat_lt   = {~feat_data[W-1], feat_data[W-2:0]}
		< {~thr_q[LAT-1][W-1], thr_q[LAT-1][W-2:0]};
	assign feat_miss = feat_data == cfg.missing_value;
	assign go_right  = feat_miss ? mr_q[LAT-1] : !feat_lt;

	// Child offset 2 * offset + 1 + right
	assign child = {cmp_ins.node_offset[`DTPU_NODE_AW-2:0], 1'b1}
		+ `DTPU_NODE_AW'(cmp_right);

	always_ff @(posedge clk) begin
		cmp_ins            <= s2_q[LAT-1];
		cmp_right          <= go_right;
		cmp_last           <= s2_q[LAT-1].level == cfg.last_level;
		recirc             <= cmp_ins;
		recirc.node_offset <= child;
		recirc.node_addr   <= cmp_ins.tree_base + child;   // Also the leaf address
		recirc.level       <= cmp_ins.level + 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cmp_v        <= 1'b0;
			recirc_valid <= 1'b0;
			leaf_rd      <= 1'b0;
		end else begin
			cmp_v        <= feat_valid;
			recirc_valid <= cmp_v && !cmp_last;   // Back to stage 1, 8 cycles on
			leaf_rd      <= cmp_v && cmp_last;
		end
	end

////////////////////////////////////////////////////////////////////////////
// Leaf output
////////////////////////////////////////////////////////////////////////////

	assign leaf_addr  = recirc.node_addr;
	assign leaf_valid = leaf_data_valid;
	assign slot_free  = leaf_data_valid && lf_q[LAT-1].last_tree;   // Tuple fully done

	always_comb begin
		leaf.value = leaf_data;
		leaf.tree  = lf_q[LAT-1].tree;
		leaf.slot  = lf_q[LAT-1].slot;
		leaf.last  = lf_q[LAT-1].last_tree;
	end

	// Issuer must give way to a returning child
	assert property (@(posedge clk) disable iff (!rst_n) !(issue_valid && recirc_valid));

	// Loop takes exactly 8 cycles from stage 1 back to stage 1
	assert property (@(posedge clk) disable iff (!rst_n) recirc_valid |-> $past(node_rd, 8));

endmodule

`default_nettype wire

/* hw/dtpu_issue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dtpu_consts.svh"

module dtpu_issue (
	input  wire                    clk,
	input  wire                    rst_n,
	input  wire dtpu_pkg::cfg_t    cfg,
	input  wire                    tuple_done,
	input  wire                    recirc_valid,
	output logic                   issue_valid,
	output dtpu_pkg::instr_t       issue
);

	logic [`DTPU_SLOT_W-1:0]  head;       // Oldest slot with trees left
	logic [`DTPU_SLOT_W:0]    pend;       // Done slots not fully issued
	logic [`DTPU_TREE_W-1:0]  tree;       // Next tree of the head slot
	logic [`DTPU_NODE_AW-1:0] base;       // tree * tree_stride, accumulated
	logic                     last_tree;
	logic                     slot_out;   // Head slot issues its last tree

	// Slots complete in round-robin order, so head and count are enough
	assign last_tree   = tree == cfg.num_trees_m1;
	assign issue_valid = pend != '0 && !recirc_valid;   // Recirculation has priority
	assign slot_out    = issue_valid && last_tree;

	always_comb begin
		issue           = '0;     // Root node at level 0
		issue.node_addr = base;
		issue.tree_base = base;
		issue.tree      = tree;
		issue.slot      = head;
		issue.last_tree = last_tree;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			head <= '0;
			pend <= '0;
			tree <= '0;
			base <= '0;
		end else begin
			pend <= pend + (`DTPU_SLOT_W+1)'(tuple_done) - (`DTPU_SLOT_W+1)'(slot_out);
			if (issue_valid) begin
				if (last_tree) begin
					tree <= '0;
					base <= '0;
					head <= head + 1'b1;   // On to the next stored tuple
				end else begin
					tree <= tree + 1'b1;
					base <= base + cfg.tree_stride;
				end
			end
		end
	end

	// Loader ready keeps the backlog within the slot count
	assert property (@(posedge clk) disable iff (!rst_n) pend <= `DTPU_SLOTS);

endmodule

`default_nettype wire

/* hw/dtpu_loader.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dtpu_consts.svh"

module dtpu_loader (
	input  wire                                         clk,
	input  wire                                         rst_n,
	input  wire                                         in_valid,
	input  wire dtpu_pkg::in_line_t                     in_line,
	output logic                                        ready,
	output dtpu_pkg::cfg_t                              cfg,
	output logic                                        w_we,
	output logic [`DTPU_NODE_AW-`DTPU_WORD_SEL_W-1:0]   w_addr,
	output logic [`DTPU_LINE_W-1:0]                     w_line,
	output logic                                        x_we,
	output logic [`DTPU_NODE_AW-`DTPU_FIDX_SEL_W-1:0]   x_addr,
	output logic [`DTPU_LINE_W-1:0]                     x_line,
	output logic                                        f_we,
	output logic [`DTPU_SLOT_W+`DTPU_SLOT_LINE_W-1:0]   f_addr,
	output logic [`DTPU_LINE_W-1:0]                     f_line,
	output logic                                        tuple_done,
	input  wire                                         slot_free
);

	logic                           cfg_wr;     // Configuration line this cycle
	logic                           tuple_wr;   // Tuple line this cycle
	logic [`DTPU_SLOT_W-1:0]        slot;       // Slot being filled
	logic [`DTPU_SLOT_LINE_W-1:0]   line_pos;   // Next line inside the slot
	logic [`DTPU_SLOT_W:0]          occ;        // Done slots not yet freed
	logic [`DTPU_SLOT_W:0]          occ_next;

////////////////////////////////////////////////////////////////////////////
// Line decode
////////////////////////////////////////////////////////////////////////////

	assign cfg_wr   = in_valid && in_line.kind == dtpu_pkg::KIND_CONFIG;
	assign tuple_wr = in_valid && in_line.kind == dtpu_pkg::KIND_TUPLE;
	assign w_we     = in_valid && in_line.kind == dtpu_pkg::KIND_WEIGHTS;
	assign x_we     = in_valid && in_line.kind == dtpu_pkg::KIND_FINDEX;
	assign f_we     = tuple_wr;

	// Every memory takes the line as it came in
	assign w_line     = in_line.data.words;
	assign x_line     = in_line.data.words;
	assign f_line     = in_line.data.words;
	assign f_addr     = {slot, line_pos};          // Slot base is slot * 4 lines
	assign tuple_done = tuple_wr && in_line.last;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cfg    <= '0;
			w_addr <= '0;
			x_addr <= '0;
		end else begin
			if (cfg_wr) begin
				cfg <= in_line.data.cfg_line.cfg;
			end
			if (w_we) begin
				w_addr <= w_addr + 1'b1;   // Weight lines fill from line 0
			end
			if (x_we) begin
				x_addr <= x_addr + 1'b1;
			end
		end
	end

////////////////////////////////////////////////////////////////////////////
// Slot accounting
////////////////////////////////////////////////////////////////////////////

	assign occ_next = occ + (`DTPU_SLOT_W+1)'(tuple_done) - (`DTPU_SLOT_W+1)'(slot_free);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			slot     <= '0;
			line_pos <= '0;
			occ      <= '0;
			ready    <= 1'b0;
		end else begin
			if (tuple_done) begin
				slot     <= slot + 1'b1;   // Round robin
				line_pos <= '0;
			end else if (tuple_wr) begin
				line_pos <= line_pos + 1'b1;
			end
			occ   <= occ_next;
			ready <= occ_next < `DTPU_SLOTS;   // A free slot for the next tuple
		end
	end

	// Pacing by ready keeps every slot held by one tuple
	assert property (@(posedge clk) disable iff (!rst_n) occ <= `DTPU_SLOTS);

endmodule

`default_nettype wire

/* hw/dtpu_line_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dtpu_consts.svh"

module dtpu_line_mem #(
	parameter int WORD_W = `DTPU_WORD_W,
	parameter int AW     = `DTPU_NODE_AW,                    // Word address width
	parameter int NUM_RD = 1,                                // Read ports, 1 or 2
	localparam int SEL_W = $clog2(`DTPU_LINE_W / WORD_W),    // Word select bits
	localparam int LAW   = AW - SEL_W                        // Line address width
) (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           we,
	input  wire  [LAW-1:0]                waddr,
	input  wire  [`DTPU_LINE_W-1:0]       din,
	input  wire  [NUM_RD-1:0]             re,
	input  wire  [NUM_RD-1:0][AW-1:0]     raddr,
	output logic [NUM_RD-1:0][WORD_W-1:0] dout,
	output logic [NUM_RD-1:0]             dout_valid
);

	logic [`DTPU_LINE_W/WORD_W-1:0][WORD_W-1:0] mem [2**LAW];

	// Entry 0 is the raw read, the rest are output registers
	logic [NUM_RD-1:0][WORD_W-1:0] data_q  [`DTPU_MEM_PIPE+1];
	logic [NUM_RD-1:0]             valid_q [`DTPU_MEM_PIPE+1];

	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= din;   // Whole line at once
		end
		for (int p = 0; p < NUM_RD; p++) begin
			if (re[p]) begin
				data_q[0][p] <= mem[raddr[p][AW-1:SEL_W]][raddr[p][SEL_W-1:0]];
			end
		end
		for (int s = 1; s <= `DTPU_MEM_PIPE; s++) begin
			data_q[s] <= data_q[s-1];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int s = 0; s <= `DTPU_MEM_PIPE; s++) begin
				valid_q[s] <= '0;
			end
		end else begin
			valid_q[0] <= re;
			for (int s = 1; s <= `DTPU_MEM_PIPE; s++) begin
				valid_q[s] <= valid_q[s-1];
			end
		end
	end

	assign dout       = data_q[`DTPU_MEM_PIPE];
	assign dout_valid = valid_q[`DTPU_MEM_PIPE];   // 1 + DTPU_MEM_PIPE cycles after re

endmodule

`default_nettype wire

/* hw/dtpu_pkg.sv */
`default_nettype none

`include "dtpu_consts.svh"

package dtpu_pkg;

	// Kind of each input line
	typedef enum logic [1:0] {
		KIND_TUPLE,
		KIND_WEIGHTS,
		KIND_FINDEX,
		KIND_CONFIG
	} line_kind_t;

	typedef struct packed {
		logic [`DTPU_WORD_W-1:0]  missing_value;  // Marks a missing feature
		logic [`DTPU_TREE_W-1:0]  num_trees_m1;
		logic [`DTPU_LEVEL_W-1:0] last_level;     // Level of the last compare
		logic [`DTPU_NODE_AW-1:0] tree_stride;    // Node words per tree
		logic [2:0]               tuple_lines;    // 1 to 4
	} cfg_t;

	// Configuration sits in the low bits of its line
	typedef struct packed {
		logic [`DTPU_LINE_W-$bits(cfg_t)-1:0] pad;
		cfg_t                                 cfg;
	} cfg_line_t;

	// Same line seen as data words or as configuration
	typedef union packed {
		logic [`DTPU_LINE_WORDS-1:0][`DTPU_WORD_W-1:0] words;
		cfg_line_t                                     cfg_line;
	} in_data_u;

	typedef struct packed {
		line_kind_t kind;
		logic       last;   // Last line of a tuple
		in_data_u   data;
	} in_line_t;

	typedef struct packed {
		logic                        missing_right;  // Route of a missing feature
		logic [2:0]                  rsvd;
		logic [`DTPU_FIDX_IDX_W-1:0] feat_idx;       // Word inside the tuple
	} fidx_entry_t;

	// One tree walk in flight
	typedef struct packed {
		logic [`DTPU_NODE_AW-1:0]  node_addr;    // tree_base + node_offset
		logic [`DTPU_NODE_AW-1:0]  tree_base;
		logic [`DTPU_NODE_AW-1:0]  node_offset;
		logic [`DTPU_LEVEL_W-1:0]  level;
		logic [`DTPU_TREE_W-1:0]   tree;
		logic [`DTPU_SLOT_W-1:0]   slot;
		logic                      last_tree;
	} instr_t;

	typedef struct packed {
		logic [`DTPU_WORD_W-1:0] value;
		logic [`DTPU_TREE_W-1:0] tree;
		logic [`DTPU_SLOT_W-1:0] slot;
		logic                    last;   // Last tree of the tuple
	} leaf_t;

endpackage

`default_nettype wire

/* hw/dtpu_consts.svh */
`ifndef DTPU_CONSTS_SVH
`define DTPU_CONSTS_SVH

// Data words and input lines
`define DTPU_WORD_W       32   // Feature, threshold and leaf word
`define DTPU_LINE_WORDS   4    // Words per input line
`define DTPU_LINE_W       128
`define DTPU_WORD_SEL_W   2    // Word select inside a line

// Tree memories
`define DTPU_NODE_AW      8    // 256 node words
`define DTPU_FIDX_W       16   // One feature-index entry
`define DTPU_FIDX_SEL_W   3    // 8 entries per line
`define DTPU_FIDX_IDX_W   12   // Feature index field of an entry
`define DTPU_FEAT_AW      8    // Feature memory word address

// Tuple slots in the feature memory
`define DTPU_SLOTS        16
`define DTPU_SLOT_W       4
`define DTPU_SLOT_LINE_W  2    // 4 lines per slot

`define DTPU_TREE_W       4    // Up to 16 trees
`define DTPU_LEVEL_W      4
`define DTPU_MEM_PIPE     2    // Registers after each memory read

`endif
